//--- hw/lsu_pkg.sv
/* Shared types and constants of the AXI load/store port.
   Modules import this package in their body and use scoped names in their port lists. */
package lsu_pkg;

  // Four hardware threads, one outstanding access each
  localparam int NUM_THREADS = 4;

  // The pipeline slice runs this far ahead of the thread that owns the access
  localparam int SLICE_LAG = 2;

  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int MASK_W     = 4;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = 8;

  // Thread number, also used as the AXI ID
  typedef logic [1:0] thread_t;

  // Destination register code in the register file
  typedef logic [2:0] reg_code_t;

  // One captured access
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] mask;
    logic [WORD_W-1:0] wdata;
    reg_code_t         rc;
  } slot_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA
  } wr_state_t;

  typedef enum logic {
    RD_IDLE,
    RD_ADDR
  } rd_state_t;

endpackage

//--- hw/lsu_thread_if.sv
/* Per-thread request state shared between the tracker and the AXI datapath blocks */
`timescale 1ns/100ps

interface lsu_thread_if;
  import lsu_pkg::*;

  slot_t                  slots [NUM_THREADS];
  logic                   req_load;
  thread_t                req_thread;
  logic [NUM_THREADS-1:0] want_write;
  logic [NUM_THREADS-1:0] want_read;
  logic                   wr_issued;
  thread_t                issued_wr_id;
  logic                   rd_issued;
  thread_t                issued_rd_id;

  modport tracker (output req_load, req_thread, want_write, want_read,
                   input wr_issued, issued_wr_id, rd_issued, issued_rd_id);
  modport store (input req_load, req_thread, output slots);
  modport writer (input want_write, slots, output wr_issued, issued_wr_id);
  modport reader (input want_read, slots, output rd_issued, issued_rd_id);
  modport formatter (input slots);

endinterface

//--- hw/lsu_tracker.sv
/* Pending and sent state per thread for the load/store port.
   Raises the thread stall while an access is outstanding and tells the issuers what to send. */
`timescale 1ns/100ps

module lsu_tracker (
  input  logic                            CLK,
  input  logic                            RST,
  input  lsu_pkg::thread_t                slice,
  input  logic                            mem_cs,
  input  logic                            mem_we,
  input  logic                            bvalid,
  input  lsu_pkg::thread_t                bid,
  input  logic                            rvalid,
  input  logic                            rlast,
  input  lsu_pkg::thread_t                rid,
  output logic [lsu_pkg::NUM_THREADS-1:0] stall,
  lsu_thread_if.tracker                   thr
);
  import lsu_pkg::*;

  logic [NUM_THREADS-1:0] pend_wr, pend_rd;
  logic [NUM_THREADS-1:0] wr_sent, rd_sent;
  logic [NUM_THREADS-1:0] wr_req, rd_req, wr_done, rd_done, wr_go, rd_go;

  function automatic logic [NUM_THREADS-1:0] onehot(input thread_t t);
    onehot    = '0;
    onehot[t] = 1'b1;
  endfunction

  // The owning thread trails the issuing slice by a fixed lag
  assign thr.req_load   = mem_cs;
  assign thr.req_thread = slice + thread_t'(SLICE_LAG);

  assign wr_req  = (mem_cs && mem_we) ? onehot(thr.req_thread) : '0;
  assign rd_req  = (mem_cs && !mem_we) ? onehot(thr.req_thread) : '0;
  assign wr_done = bvalid ? onehot(bid) : '0;
  assign rd_done = (rvalid && rlast) ? onehot(rid) : '0;
  assign wr_go   = thr.wr_issued ? onehot(thr.issued_wr_id) : '0;
  assign rd_go   = thr.rd_issued ? onehot(thr.issued_rd_id) : '0;

  // A thread wants a transaction until its issuer has finished sending it
  assign thr.want_write = pend_wr & ~wr_sent;
  assign thr.want_read  = pend_rd & ~rd_sent;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      pend_wr <= '0;
      pend_rd <= '0;
      wr_sent <= '0;
      rd_sent <= '0;
      stall   <= '0;
    end
    else
    begin
      pend_wr <= (pend_wr & ~wr_done) | wr_req;
      pend_rd <= (pend_rd & ~rd_done) | rd_req;
      wr_sent <= (wr_sent | wr_go) & ~wr_done;
      rd_sent <= (rd_sent | rd_go) & ~rd_done;
      stall   <= pend_wr | pend_rd;
    end
  end

endmodule

//--- hw/lsu_slots.sv
/* Holds the captured access of each thread.
   A slot is written on the request strobe and read by the issuers and the load formatter. */
`timescale 1ns/100ps

module lsu_slots (
  input  logic                       CLK,
  input  logic [lsu_pkg::ADDR_W-1:0] mem_addr,
  input  logic [lsu_pkg::MASK_W-1:0] mem_mask,
  input  logic [lsu_pkg::WORD_W-1:0] mem_wdata,
  input  lsu_pkg::reg_code_t         mem_rc,
  lsu_thread_if.store                thr
);

  // Only the owning thread's slot changes, the others keep their access
  always_ff @(posedge CLK)
  begin
    if (thr.req_load)
    begin
      thr.slots[thr.req_thread] <= '{
        addr:  mem_addr,
        mask:  mem_mask,
        wdata: mem_wdata,
        rc:    mem_rc
      };
    end
  end

endmodule

//--- hw/lsu_write_issue.sv
/* Sends pending stores as single-beat AW then W transactions.
   Threads are visited in round-robin order, one scan step per cycle. */
`timescale 1ns/100ps

module lsu_write_issue (
  input  logic                           CLK,
  input  logic                           RST,
  output lsu_pkg::thread_t               awid,
  output logic [lsu_pkg::ADDR_W-1:0]     awaddr,
  output logic                           awvalid,
  input  logic                           awready,
  output logic [lsu_pkg::AXI_DATA_W-1:0] wdata,
  output logic [lsu_pkg::AXI_STRB_W-1:0] wstrb,
  output logic                           wvalid,
  input  logic                           wready,
  lsu_thread_if.writer                   thr
);
  import lsu_pkg::*;

  wr_state_t state;
  thread_t   ptr;
  slot_t     cur;
  logic      start;

  // The pointer stays on the chosen thread until its W beat is accepted
  assign cur   = thr.slots[ptr];
  assign start = (state == WR_IDLE) && thr.want_write[ptr];

  assign thr.wr_issued    = wvalid && wready;
  assign thr.issued_wr_id = ptr;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      state   <= WR_IDLE;
      ptr     <= '0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end
    else
    begin
      case (state)
        WR_IDLE:
          if (start)
          begin
            awvalid <= 1'b1;
            state   <= WR_ADDR;
          end
          else
            ptr <= ptr + 1'b1;
        WR_ADDR:
          if (awready)
          begin
            awvalid <= 1'b0;
            wvalid  <= 1'b1;
            state   <= WR_DATA;
          end
        WR_DATA:
          if (wready)
          begin
            wvalid <= 1'b0;
            ptr    <= ptr + 1'b1;
            state  <= WR_IDLE;
          end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // Store data goes out on both halves, the strobe picks the word by address bit 2
  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      awid   <= ptr;
      awaddr <= cur.addr;
    end
    if (state == WR_ADDR && awready)
    begin
      wdata <= {cur.wdata, cur.wdata};
      wstrb <= cur.addr[2] ? {cur.mask, 4'b0000} : {4'b0000, cur.mask};
    end
  end

endmodule

//--- hw/lsu_read_issue.sv
/* Sends pending loads as single-beat AR transactions.
   Threads are visited in round-robin order, one scan step per cycle. */
`timescale 1ns/100ps

module lsu_read_issue (
  input  logic                       CLK,
  input  logic                       RST,
  output lsu_pkg::thread_t           arid,
  output logic [lsu_pkg::ADDR_W-1:0] araddr,
  output logic                       arvalid,
  input  logic                       arready,
  lsu_thread_if.reader               thr
);
  import lsu_pkg::*;

  rd_state_t state;
  thread_t   ptr;
  logic      start;

  assign start = (state == RD_IDLE) && thr.want_read[ptr];

  // The AR handshake is the last thing this block sends for a load
  assign thr.rd_issued    = arvalid && arready;
  assign thr.issued_rd_id = ptr;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      state   <= RD_IDLE;
      ptr     <= '0;
      arvalid <= 1'b0;
    end
    else if (state == RD_IDLE)
    begin
      if (start)
      begin
        arvalid <= 1'b1;
        state   <= RD_ADDR;
      end
      else
        ptr <= ptr + 1'b1;
    end
    else if (arready)
    begin
      arvalid <= 1'b0;
      ptr     <= ptr + 1'b1;
      state   <= RD_IDLE;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      arid   <= ptr;
      araddr <= thr.slots[ptr].addr;
    end
  end

endmodule

//--- hw/lsu_load_format.sv
/* Two-stage path from the R channel to the register file write port.
   Picks the word by address bit 2 and zero-extends a byte or half-word by the mask. */
`timescale 1ns/100ps

module lsu_load_format (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           rvalid,
  input  lsu_pkg::thread_t               rid,
  input  logic [lsu_pkg::AXI_DATA_W-1:0] rdata,
  output logic                           load_vld,
  output lsu_pkg::thread_t               load_thread,
  output lsu_pkg::reg_code_t             load_sel,
  output logic [lsu_pkg::WORD_W-1:0]     load_data,
  lsu_thread_if.formatter                thr
);
  import lsu_pkg::*;

  logic                  beat_vld;
  thread_t               beat_id;
  logic [AXI_DATA_W-1:0] beat_data;
  slot_t                 req;
  logic [WORD_W-1:0]     word, result;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      beat_vld <= 1'b0;
      load_vld <= 1'b0;
    end
    else
    begin
      beat_vld <= rvalid;
      load_vld <= beat_vld;
    end
  end

  // The slot still holds the request, its thread stays stalled until the result is out
  assign req  = thr.slots[beat_id];
  assign word = req.addr[2] ? beat_data[AXI_DATA_W-1:WORD_W] : beat_data[WORD_W-1:0];

  always_comb
  begin
    case (req.mask)
      4'b0001: result = {24'd0, word[7:0]};
      4'b0010: result = {24'd0, word[15:8]};
      4'b0100: result = {24'd0, word[23:16]};
      4'b1000: result = {24'd0, word[31:24]};
      4'b0011: result = {16'd0, word[15:0]};
      4'b1100: result = {16'd0, word[31:16]};
      default: result = word;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    beat_id     <= rid;
    beat_data   <= rdata;
    load_thread <= beat_id;
    load_sel    <= req.rc;
    load_data   <= result;
  end

endmodule

//--- hw/lsu_axi_top.sv
/* AXI load/store port of the four-thread barrel processor.
   Takes memory strobes from the pipeline, stalls the thread and returns load data. */
`timescale 1ns/100ps

module lsu_axi_top (
  input  logic                            CLK,
  input  logic                            RST,
  // Pipeline side
  input  lsu_pkg::thread_t                slice,
  input  logic                            mem_cs,
  input  logic                            mem_we,
  input  logic [lsu_pkg::ADDR_W-1:0]      mem_addr,
  input  logic [lsu_pkg::MASK_W-1:0]      mem_mask,
  input  logic [lsu_pkg::WORD_W-1:0]      mem_wdata,
  input  lsu_pkg::reg_code_t              mem_rc,
  output logic [lsu_pkg::NUM_THREADS-1:0] stall,
  // AXI write channels
  output lsu_pkg::thread_t                awid,
  output logic [lsu_pkg::ADDR_W-1:0]      awaddr,
  output logic                            awvalid,
  input  logic                            awready,
  output logic [lsu_pkg::AXI_DATA_W-1:0]  wdata,
  output logic [lsu_pkg::AXI_STRB_W-1:0]  wstrb,
  output logic                            wvalid,
  input  logic                            wready,
  input  lsu_pkg::thread_t                bid,
  input  logic                            bvalid,
  output logic                            bready,
  // AXI read channels
  output lsu_pkg::thread_t                arid,
  output logic [lsu_pkg::ADDR_W-1:0]      araddr,
  output logic                            arvalid,
  input  logic                            arready,
  input  lsu_pkg::thread_t                rid,
  input  logic [lsu_pkg::AXI_DATA_W-1:0]  rdata,
  input  logic                            rlast,
  input  logic                            rvalid,
  output logic                            rready,
  // Register file side
  output logic                            load_vld,
  output lsu_pkg::thread_t                load_thread,
  output lsu_pkg::reg_code_t              load_sel,
  output logic [lsu_pkg::WORD_W-1:0]      load_data
);

  lsu_thread_if thr ();

  // Responses are always accepted
  assign bready = 1'b1;
  assign rready = 1'b1;

  lsu_tracker i_tracker (
    .CLK    (CLK),
    .RST    (RST),
    .slice  (slice),
    .mem_cs (mem_cs),
    .mem_we (mem_we),
    .bvalid (bvalid),
    .bid    (bid),
    .rvalid (rvalid),
    .rlast  (rlast),
    .rid    (rid),
    .stall  (stall),
    .thr    (thr.tracker)
  );

  lsu_slots i_slots (
    .CLK       (CLK),
    .mem_addr  (mem_addr),
    .mem_mask  (mem_mask),
    .mem_wdata (mem_wdata),
    .mem_rc    (mem_rc),
    .thr       (thr.store)
  );

  lsu_write_issue i_write_issue (
    .CLK     (CLK),
    .RST     (RST),
    .awid    (awid),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .thr     (thr.writer)
  );

  lsu_read_issue i_read_issue (
    .CLK     (CLK),
    .RST     (RST),
    .arid    (arid),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .thr     (thr.reader)
  );

  lsu_load_format i_load_format (
    .CLK         (CLK),
    .RST         (RST),
    .rvalid      (rvalid),
    .rid         (rid),
    .rdata       (rdata),
    .load_vld    (load_vld),
    .load_thread (load_thread),
    .load_sel    (load_sel),
    .load_data   (load_data),
    .thr         (thr.formatter)
  );

endmodule

//--- sim/lsu_axi_properties.sv
/* AXI valid/ready rules for the write and read issuers.
   Bound to both issuers, the read side ties the data channel off. */
`timescale 1ns/100ps

module lsu_axi_properties (
  input logic        CLK,
  input logic        RST,
  input logic        avalid,
  input logic        aready,
  input logic [31:0] aaddr,
  input logic [1:0]  aid,
  input logic        dvalid,
  input logic        dready,
  input logic [63:0] ddata,
  input logic [7:0]  dstrb
);

  // An address beat stays put until it is accepted
  a_addr_stable: assert property (@(posedge CLK) disable iff (RST)
    avalid && !aready |=> avalid && $stable(aaddr) && $stable(aid))
    else $error("address channel changed before its ready");

  a_data_stable: assert property (@(posedge CLK) disable iff (RST)
    dvalid && !dready |=> dvalid && $stable(ddata) && $stable(dstrb))
    else $error("data channel changed before its ready");

  // The issuer sends the address first and the data afterwards
  a_addr_data_apart: assert property (@(posedge CLK) disable iff (RST)
    !(avalid && dvalid))
    else $error("address and data valid high together");

endmodule

bind lsu_write_issue lsu_axi_properties i_wr_props (
  .CLK(CLK), .RST(RST), .avalid(awvalid), .aready(awready), .aaddr(awaddr), .aid(awid),
  .dvalid(wvalid), .dready(wready), .ddata(wdata), .dstrb(wstrb)
);

bind lsu_read_issue lsu_axi_properties i_rd_props (
  .CLK(CLK), .RST(RST), .avalid(arvalid), .aready(arready), .aaddr(araddr), .aid(arid),
  .dvalid(1'b0), .dready(1'b1), .ddata(64'd0), .dstrb(8'd0)
);

//--- sim/tb_lsu_axi_top.sv
/* Directed testbench for the AXI load/store port.
   A responder models AXI memory, tasks issue accesses and check stall, AXI and load results. */
`timescale 1ns/100ps

module tb_lsu_axi_top;
  import lsu_pkg::*;

  // Five tests that each finish well within 400 cycles
  localparam int MAX_CYCLES = 5 * 400;

  logic CLK, RST;
  thread_t slice;
  logic mem_cs, mem_we;
  logic [31:0] mem_addr, mem_wdata;
  logic [3:0] mem_mask;
  reg_code_t mem_rc;
  logic [3:0] stall;
  thread_t awid, bid, arid, rid, load_thread;
  logic [31:0] awaddr, araddr, load_data;
  logic [63:0] wdata, rdata;
  logic [7:0] wstrb;
  logic awvalid, wvalid, wready, bvalid, bready, aw_hold;
  logic arvalid, arready, rlast, rvalid, rready, load_vld;
  reg_code_t load_sel;
  wire awready = !aw_hold;
  int cycles;

  logic [63:0] mem [int unsigned];
  thread_t aw_ids[$];
  logic [31:0] aw_addrs[$];
  logic [63:0] w_datas[$];
  logic [7:0] w_strbs[$];
  logic [31:0] ar_addrs[$];
  thread_t lq_thread[$];
  reg_code_t lq_sel[$];
  logic [31:0] lq_data[$];

  lsu_axi_top i_dut (.*);

  always #2 CLK = !CLK;

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles == MAX_CYCLES)
      abort_run("Timeout: the run did not finish within the cycle limit");
  end

  // Load results are collected here and checked by the tests
  always @(posedge CLK)
  begin
    #1;
    if (load_vld)
    begin
      lq_thread.push_back(load_thread);
      lq_sel.push_back(load_sel);
      lq_data.push_back(load_data);
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_thread(input string name, input thread_t got, input thread_t exp);
    if (got !== exp)
    begin
      $display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run("Thread number mismatch");
    end
  endtask

  task automatic check_rc(input string name, input reg_code_t got, input reg_code_t exp);
    if (got !== exp)
    begin
      $display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run("Register code mismatch");
    end
  endtask

  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run("Data mismatch");
    end
  endtask

  task automatic check_stall(input logic [3:0] exp);
    if (stall !== exp)
    begin
      $display("Fail at %0d ns: stall is %b, expected %b", $time, stall, exp);
      abort_run("Stall mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      abort_run("Control flag mismatch");
    end
  endtask

  task automatic drive_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic sample_cycle();
    @(posedge CLK);
    #3;
  endtask

  // Unwritten memory reads back a pattern built from the aligned address
  function automatic logic [63:0] mem_read(input logic [31:0] addr);
    logic [31:0] al;
    al = {addr[31:3], 3'b000};
    if (mem.exists(addr >> 3))
      return mem[addr >> 3];
    return {~al, al};
  endfunction

  function automatic logic [31:0] fmt_load(input logic [63:0] beat, input logic [31:0] addr,
                                           input logic [3:0] mask);
    logic [31:0] w;
    w = addr[2] ? beat[63:32] : beat[31:0];
    case (mask)
      4'b0001, 4'b0010, 4'b0100, 4'b1000:
        for (int i = 0; i < 4; i++)
          if (mask[i])
            return {24'd0, w[8*i +: 8]};
      4'b0011: return {16'd0, w[15:0]};
      4'b1100: return {16'd0, w[31:16]};
      default: return w;
    endcase
    return w;
  endfunction

  task automatic serve_writes();
    thread_t id_q;
    logic [31:0] addr_q;
    logic [63:0] line;
    logic b_due;
    id_q   = '0;
    addr_q = '0;
    b_due  = 1'b0;
    forever
    begin
      drive_cycle();
      bvalid = b_due;
      bid    = id_q;
      b_due  = 1'b0;
      @(negedge CLK);
      if (awvalid && awready)
      begin
        id_q   = awid;
        addr_q = awaddr;
        aw_ids.push_back(awid);
        aw_addrs.push_back(awaddr);
      end
      if (wvalid && wready)
      begin
        line = mem_read(addr_q);
        for (int b = 0; b < 8; b++)
          if (wstrb[b])
            line[8*b +: 8] = wdata[8*b +: 8];
        mem[addr_q >> 3] = line;
        w_datas.push_back(wdata);
        w_strbs.push_back(wstrb);
        b_due = 1'b1;
      end
    end
  endtask

  task automatic serve_reads();
    thread_t id_q;
    logic [31:0] addr_q;
    logic r_due;
    id_q   = '0;
    addr_q = '0;
    r_due  = 1'b0;
    forever
    begin
      drive_cycle();
      rvalid = r_due;
      rlast  = r_due;
      rid    = id_q;
      rdata  = mem_read(addr_q);
      r_due  = 1'b0;
      @(negedge CLK);
      if (arvalid && arready)
      begin
        id_q   = arid;
        addr_q = araddr;
        ar_addrs.push_back(araddr);
        r_due  = 1'b1;
      end
    end
  endtask

  // Drives a one-cycle request strobe and returns one drive slot after the sampling edge
  task automatic issue_access(input thread_t s, input logic we, input logic [31:0] addr,
                              input logic [3:0] mask, input logic [31:0] data,
                              input reg_code_t rc);
    drive_cycle();
    slice     = s;
    mem_cs    = 1'b1;
    mem_we    = we;
    mem_addr  = addr;
    mem_mask  = mask;
    mem_wdata = data;
    mem_rc    = rc;
    drive_cycle();
    mem_cs    = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do
    begin
      sample_cycle();
      n++;
      if (n > 80)
        abort_run("A thread stayed stalled, its access never completed");
    end
    while (stall != 4'b0000);
  endtask

  task automatic check_next_load(input thread_t t, input reg_code_t rc, input logic [31:0] d);
    int n;
    n = 0;
    while (lq_data.size() == 0)
    begin
      sample_cycle();
      n++;
      if (n > 40)
        abort_run("No load result came back for a load request");
    end
    check_thread("load_thread", lq_thread.pop_front(), t);
    check_rc("load_sel", lq_sel.pop_front(), rc);
    check_data("load_data", lq_data.pop_front(), d);
  endtask

  task automatic test_reset_and_store();
    logic [63:0] w;
    check_stall(4'b0000);
    check_flag("awvalid", awvalid, 1'b0);
    check_flag("wvalid", wvalid, 1'b0);
    check_flag("arvalid", arvalid, 1'b0);
    check_flag("load_vld", load_vld, 1'b0);
    check_flag("bready", bready, 1'b1);
    check_flag("rready", rready, 1'b1);
    aw_ids.delete();
    aw_addrs.delete();
    w_datas.delete();
    w_strbs.delete();
    issue_access(2'd1, 1'b1, 32'h0000_1004, 4'b0011, 32'ha5b6_c7d8, 3'd0);
    sample_cycle();
    wait_idle();
    check_thread("awid", aw_ids.pop_front(), 2'd3);
    check_data("awaddr", aw_addrs.pop_front(), 32'h0000_1004);
    w = w_datas.pop_front();
    check_data("wdata upper", w[63:32], 32'ha5b6_c7d8);
    check_data("wdata lower", w[31:0], 32'ha5b6_c7d8);
    check_data("wstrb", {24'd0, w_strbs.pop_front()}, 32'h0000_0030);
    issue_access(2'd2, 1'b1, 32'h0000_1010, 4'b1000, 32'h1122_3344, 3'd0);
    sample_cycle();
    wait_idle();
    check_thread("awid", aw_ids.pop_front(), 2'd0);
    void'(w_datas.pop_front());
    check_data("wstrb", {24'd0, w_strbs.pop_front()}, 32'h0000_0008);
  endtask

  task automatic test_load_format();
    logic [3:0] masks [7];
    logic [31:0] addr;
    thread_t s;
    masks = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
    mem[32'h200 >> 3] = 64'h8877_6655_4433_2211;
    for (int i = 0; i < 14; i++)
    begin
      addr = (i < 7) ? 32'h200 : 32'h204;
      s    = thread_t'(i);
      issue_access(s, 1'b0, addr, masks[i % 7], 32'd0, reg_code_t'(i));
      check_next_load(s + 2'd2, reg_code_t'(i), fmt_load(mem_read(addr), addr, masks[i % 7]));
      check_data("araddr", ar_addrs.pop_front(), addr);
      wait_idle();
    end
  endtask

  task automatic test_stall_timing();
    issue_access(2'd0, 1'b1, 32'h0000_2000, 4'b1111, 32'hcafe_0001, 3'd2);
    check_stall(4'b0000);
    sample_cycle();
    check_stall(4'b0100);
    while (!bvalid)
      sample_cycle();
    sample_cycle();
    check_stall(4'b0100);
    sample_cycle();
    check_stall(4'b0000);
  endtask

  // Holding AW lets all four requests become pending before the first one goes out
  task automatic test_round_robin();
    aw_ids.delete();
    drive_cycle();
    aw_hold = 1'b1;
    for (int i = 0; i < 4; i++)
      issue_access(thread_t'(i), 1'b1, 32'h3000 + 32'(8 * i), 4'b1111, $urandom, 3'd1);
    drive_cycle();
    aw_hold = 1'b0;
    wait_idle();
    check_data("AW count", 32'(aw_ids.size()), 32'd4);
    for (int i = 1; i < 4; i++)
      check_thread("awid order", aw_ids[i], aw_ids[i-1] + 2'd1);
  endtask

  task automatic test_aw_backpressure();
    int n;
    drive_cycle();
    aw_hold = 1'b1;
    issue_access(2'd0, 1'b1, 32'h0000_4000, 4'b1111, 32'h5555_aaaa, 3'd3);
    issue_access(2'd1, 1'b0, 32'h0000_0204, 4'b1111, 32'd0, 3'd4);
    n = 0;
    while (!awvalid)
    begin
      sample_cycle();
      n++;
      if (n > 20)
        abort_run("AWVALID never rose for a pending store");
    end
    check_data("awaddr", awaddr, 32'h0000_4000);
    for (int i = 0; i < 10; i++)
    begin
      sample_cycle();
      check_flag("awvalid", awvalid, 1'b1);
      check_data("awaddr", awaddr, 32'h0000_4000);
    end
    check_flag("load done under AW hold", lq_data.size() > 0, 1'b1);
    check_next_load(2'd3, 3'd4, fmt_load(mem_read(32'h204), 32'h204, 4'b1111));
    drive_cycle();
    aw_hold = 1'b0;
    wait_idle();
  endtask

  initial
  begin
    void'($urandom(32'hd60e));
    CLK = 1'b0;
    RST = 1'b1;
    cycles = 0;
    slice = '0;
    mem_cs = 1'b0;
    mem_we = 1'b0;
    mem_addr = '0;
    mem_mask = '0;
    mem_wdata = '0;
    mem_rc = '0;
    aw_hold = 1'b0;
    wready = 1'b1;
    arready = 1'b1;
    bvalid = 1'b0;
    bid = '0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rid = '0;
    rdata = '0;
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;
    fork
      serve_writes();
      serve_reads();
    join_none
    sample_cycle();
    test_reset_and_store();
    test_load_format();
    test_stall_timing();
    test_round_robin();
    test_aw_backpressure();
    $display("all tests passed");
    $finish;
  end

endmodule

//--- filelist.f
hw/lsu_pkg.sv
hw/lsu_thread_if.sv
hw/lsu_tracker.sv
hw/lsu_slots.sv
hw/lsu_write_issue.sv
hw/lsu_read_issue.sv
hw/lsu_load_format.sv
hw/lsu_axi_top.sv
sim/lsu_axi_properties.sv
sim/tb_lsu_axi_top.sv

//--- Makefile
# Verilator simulation of the AXI load/store port

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module tb_lsu_axi_top -o sim_lsu
	-./obj_dir/sim_lsu > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
